/* verilog/axi3ReadPkg.sv */
package axi3ReadPkg;

	// ======================================================================
	// Bus widths
	// ======================================================================
	localparam int addrWidth = 32;         // Byte address
	localparam int dataWidth = 32;         // One beat on both sides
	localparam int idWidth   = 4;          // Transaction ID

	// Buffer depths as log2 of the entry count
	localparam int idFifoDepthLog2   = 3;  // Up to 8 requests in flight
	localparam int dataFifoDepthLog2 = 4;  // 16 buffered slave beats

	// Burst limits
	localparam int axi3MaxBeats = 16;      // Beats in a full AXI3 segment

	// ======================================================================
	// Typed vectors
	// ======================================================================
	typedef logic [addrWidth-1:0] addrT;
	typedef logic [dataWidth-1:0] dataT;
	typedef logic [idWidth-1:0]   idT;
	typedef logic [7:0]           axi4LenT;   // Beats minus one, up to 256
	typedef logic [3:0]           axi3LenT;   // Beats minus one, up to 16
	typedef logic [2:0]           sizeT;      // Bytes per beat as log2
	typedef logic [1:0]           burstT;
	typedef logic [1:0]           lockT;      // AXI3 lock encoding
	typedef logic [3:0]           cacheT;
	typedef logic [2:0]           protT;
	typedef logic [1:0]           respT;

	localparam burstT burstFixed = 2'b00;     // Every beat at the same address

	// ======================================================================
	// State machines
	// ======================================================================
	typedef enum logic {arIdle, arIssue} arStateT;  // Address split
	typedef enum logic {rIdle, rSend} rStateT;      // Upstream data return

endpackage

/* verilog/syncFifo.sv */
`timescale 1ns/100ps

module syncFifo #(
	parameter int fifoWidth = 8,   // Bits per entry
	parameter int depthLog2 = 3    // Entry count as log2
) (
	input  logic                 ACLK,
	input  logic                 sysReset,
	input  logic                 push,      // Ignored while full
	input  logic [fifoWidth-1:0] pushData,
	input  logic                 pop,       // Ignored while empty
	output logic [fifoWidth-1:0] popData,   // Head entry, valid while not empty
	output logic                 empty,
	output logic                 full
);

	// Storage array
	logic [fifoWidth-1:0] mem [2**depthLog2];

	// Pointers carry one extra wrap bit
	logic [depthLog2:0] wrPtr;
	logic [depthLog2:0] rdPtr;
	logic               wrEn;
	logic               rdEn;

	assign wrEn = push && !full;
	assign rdEn = pop && !empty;

	// Same index and same lap means empty, same index on another lap means full
	assign empty = (wrPtr == rdPtr);
	assign full  = (wrPtr[depthLog2] != rdPtr[depthLog2]) &&
		(wrPtr[depthLog2-1:0] == rdPtr[depthLog2-1:0]);

	// First word fall through
	assign popData = mem[rdPtr[depthLog2-1:0]];

	always_ff @(posedge ACLK)
	begin
		if (wrEn)
			mem[wrPtr[depthLog2-1:0]] <= pushData;
	end

	// Pointer update
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
		end
	end

endmodule

/* verilog/arSplitFsm.sv */
`timescale 1ns/100ps

module arSplitFsm import axi3ReadPkg::*; (
	input  logic ACLK,
	input  logic sysReset,
	// AXI4 request handshake
	input  logic arValid,
	output logic arReady,
	input  logic idFifoFull,     // No room for another request record
	// Segment generator
	input  logic lastSeg,        // Current segment is the final one
	output logic loadReq,        // Latch the accepted request
	output logic advanceSeg,     // Step to the next segment
	// AXI3 address handshake
	output logic slaveArValid,
	input  logic slaveArReady,
	// Request record into the ID FIFO
	output logic reqPush
);

	arStateT state;
	arStateT nextState;
	logic    segAccept;          // AXI3 address handshake this cycle

	// ======================================================================
	// Handshake decode
	// ======================================================================

	// Only accept when the record can be stored
	assign arReady = (state == arIdle) && arValid && !idFifoFull;

	// Acceptance latches the request and logs its record in one cycle
	assign loadReq = arReady;
	assign reqPush = arReady;

	assign slaveArValid = (state == arIssue);    // Segment presented in every issue cycle
	assign segAccept    = slaveArValid && slaveArReady;
	assign advanceSeg   = segAccept && !lastSeg; // Final segment leaves the counter alone

	// ======================================================================
	// State machine
	// ======================================================================
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			state <= arIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			arIdle:
			begin
				if (arReady)
					nextState = arIssue;     // First segment next cycle
			end
			arIssue:
			begin
				if (segAccept && lastSeg)
					nextState = arIdle;      // Whole request issued
			end
			default:
				nextState = arIdle;
		endcase
	end

endmodule

/* verilog/arSegmentGen.sv */
`timescale 1ns/100ps

module arSegmentGen import axi3ReadPkg::*; (
	input  logic    ACLK,
	input  logic    sysReset,
	input  logic    loadReq,       // Request accepted this cycle
	input  logic    advanceSeg,    // Current segment accepted, more follow
	// AXI4 request attributes
	input  idT      arId,
	input  addrT    arAddr,
	input  axi4LenT arLen,
	input  sizeT    arSize,
	input  burstT   arBurst,
	input  lockT    arLock,
	input  cacheT   arCache,
	input  protT    arProt,
	output logic    lastSeg,       // Counter has run out
	// AXI3 segment attributes
	output idT      slaveArId,
	output addrT    slaveArAddr,
	output axi3LenT slaveArLen,
	output sizeT    slaveArSize,
	output burstT   slaveArBurst,
	output lockT    slaveArLock,
	output cacheT   slaveArCache,
	output protT    slaveArProt
);

	// Latched request
	idT      latId;
	sizeT    latSize;
	burstT   latBurst;
	lockT    latLock;
	cacheT   latCache;
	protT    latProt;
	axi3LenT lastLen;      // Length of the final segment

	addrT    segAddr;      // Address of the segment on the bus
	addrT    alignMask;    // Clears the sub-beat address bits
	addrT    segStride;    // Bytes covered by a full segment
	addrT    nextAddr;
	axi3LenT segCount;     // Segments still to follow the current one

	// ======================================================================
	// Segment address arithmetic
	// ======================================================================
	assign alignMask = ~((addrT'(1) << latSize) - addrT'(1));
	assign segStride = addrT'(axi3MaxBeats) << latSize;  // 16 beats of the burst size
	assign nextAddr  = (segAddr & alignMask) + segStride;

	// Request attributes and segment address
	always_ff @(posedge ACLK)
	begin
		if (loadReq)
		begin
			latId    <= arId;
			latSize  <= arSize;
			latBurst <= arBurst;
			latLock  <= arLock;
			latCache <= arCache;
			latProt  <= arProt;
			lastLen  <= arLen[3:0];   // Remainder beats
			segAddr  <= arAddr;       // First segment at the original address
		end
		else if (advanceSeg && (latBurst != burstFixed))
			segAddr <= nextAddr;      // FIXED bursts keep their address
	end

	// Segment counter
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			segCount <= '0;
		else if (loadReq)
			segCount <= arLen[7:4];   // Number of full segments before the last
		else if (advanceSeg)
			segCount <= segCount - 1'b1;
	end

	// ======================================================================
	// Segment outputs
	// ======================================================================
	assign lastSeg    = (segCount == '0);
	assign slaveArLen = lastSeg ? lastLen : axi3LenT'(axi3MaxBeats - 1);

	assign slaveArId    = latId;
	assign slaveArAddr  = segAddr;
	assign slaveArSize  = latSize;
	assign slaveArBurst = latBurst;
	assign slaveArLock  = latLock;
	assign slaveArCache = latCache;
	assign slaveArProt  = latProt;

endmodule

/* verilog/rdataReturn.sv */
`timescale 1ns/100ps

module rdataReturn import axi3ReadPkg::*; (
	input  logic ACLK,
	input  logic sysReset,
	// Request record FIFO head
	input  logic [$bits(idT)+$bits(axi4LenT)-1:0] reqRecord,  // ID above the AXI4 length
	input  logic reqEmpty,
	output logic reqPop,
	// Data FIFO head
	input  dataT beatData,
	input  respT beatResp,
	input  logic beatEmpty,
	output logic beatPop,
	// AXI4 read data channel
	output idT   rId,
	output dataT rData,
	output respT rResp,
	output logic rLast,
	output logic rValid,
	input  logic rReady
);

	rStateT  state;
	rStateT  nextState;
	idT      recId;        // ID of the burst at the head
	axi4LenT recLen;       // Its AXI4 length
	axi4LenT beatCount;    // Beats left after the current one
	logic    beatAccept;   // Upstream handshake this cycle
	logic    finalBeat;    // Counter at zero

	assign {recId, recLen} = reqRecord;

	// ======================================================================
	// Upstream beat decode
	// ======================================================================
	assign finalBeat  = (beatCount == '0);
	assign rValid     = (state == rSend) && !beatEmpty;  // Wait for each slave beat
	assign rLast      = rValid && finalBeat;
	assign beatAccept = rValid && rReady;

	assign rId   = recId;       // Restored from the request, not the slave
	assign rData = beatData;
	assign rResp = beatResp;

	assign beatPop = beatAccept;
	assign reqPop  = beatAccept && finalBeat;  // Record retires with the burst

	// Beat counter
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			beatCount <= '0;
		else if ((state == rIdle) && (nextState == rSend))
			beatCount <= recLen;                 // Full AXI4 burst length
		else if (beatAccept && !finalBeat)
			beatCount <= beatCount - 1'b1;
	end

	// ======================================================================
	// State machine
	// ======================================================================
	always_ff @(posedge ACLK or negedge sysReset)
	begin
		if (!sysReset)
			state <= rIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			rIdle:
			begin
				if (!beatEmpty && !reqEmpty)
					nextState = rSend;   // Data waiting and its request known
			end
			rSend:
			begin
				if (beatAccept && finalBeat)
					nextState = rIdle;   // Idle cycle between bursts
			end
			default:
				nextState = rIdle;
		endcase
	end

endmodule

/* verilog/readProtConv.sv */
`timescale 1ns/100ps

module readProtConv import axi3ReadPkg::*; (
	input  logic    ACLK,
	input  logic    sysReset,

	// AXI4 read address from the upstream master
	input  idT      arId,
	input  addrT    arAddr,
	input  axi4LenT arLen,
	input  sizeT    arSize,
	input  burstT   arBurst,
	input  lockT    arLock,
	input  cacheT   arCache,
	input  protT    arProt,
	input  logic    arValid,
	output logic    arReady,

	// AXI4 read data to the upstream master
	output idT      rId,
	output dataT    rData,
	output respT    rResp,
	output logic    rLast,
	output logic    rValid,
	input  logic    rReady,

	// AXI3 read address to the slave
	output idT      slaveArId,
	output addrT    slaveArAddr,
	output axi3LenT slaveArLen,
	output sizeT    slaveArSize,
	output burstT   slaveArBurst,
	output lockT    slaveArLock,
	output cacheT   slaveArCache,
	output protT    slaveArProt,
	output logic    slaveArValid,
	input  logic    slaveArReady,

	// AXI3 read data from the slave
	input  dataT    slaveRData,
	input  respT    slaveRResp,
	input  logic    slaveRLast,     // Upstream RLAST is rebuilt from the AXI4 length
	input  logic    slaveRValid,
	output logic    slaveRReady
);

	// Request record path
	logic                                 reqPush;
	logic                                 reqPop;
	logic                                 reqEmpty;
	logic                                 reqFull;
	logic [$bits(idT)+$bits(axi4LenT)-1:0] reqRecord;

	// Slave beat path
	logic                                 beatPop;
	logic                                 beatEmpty;
	logic                                 beatFull;
	logic [$bits(dataT)+$bits(respT)-1:0] beatHead;
	dataT                                 beatData;
	respT                                 beatResp;

	// Segment control
	logic loadReq;
	logic advanceSeg;
	logic lastSeg;

	// ======================================================================
	// Buffers
	// ======================================================================
	syncFifo #(.fifoWidth(idWidth + 8), .depthLog2(idFifoDepthLog2)) reqFifo (
		.ACLK(ACLK), .sysReset(sysReset),
		.push(reqPush), .pushData({arId, arLen}),
		.pop(reqPop), .popData(reqRecord),
		.empty(reqEmpty), .full(reqFull)
	);

	assign slaveRReady = !beatFull;   // Beat enters in the cycle of its handshake

	syncFifo #(.fifoWidth(dataWidth + 2), .depthLog2(dataFifoDepthLog2)) beatFifo (
		.ACLK(ACLK), .sysReset(sysReset),
		.push(slaveRValid), .pushData({slaveRData, slaveRResp}),
		.pop(beatPop), .popData(beatHead),
		.empty(beatEmpty), .full(beatFull)
	);

	assign {beatData, beatResp} = beatHead;

	// ======================================================================
	// Address split and data return
	// ======================================================================
	arSplitFsm arFsm (
		.ACLK(ACLK), .sysReset(sysReset),
		.arValid(arValid), .arReady(arReady), .idFifoFull(reqFull),
		.lastSeg(lastSeg), .loadReq(loadReq), .advanceSeg(advanceSeg),
		.slaveArValid(slaveArValid), .slaveArReady(slaveArReady),
		.reqPush(reqPush)
	);

	arSegmentGen segGen (
		.ACLK(ACLK), .sysReset(sysReset),
		.loadReq(loadReq), .advanceSeg(advanceSeg),
		.arId(arId), .arAddr(arAddr), .arLen(arLen), .arSize(arSize),
		.arBurst(arBurst), .arLock(arLock), .arCache(arCache), .arProt(arProt),
		.lastSeg(lastSeg),
		.slaveArId(slaveArId), .slaveArAddr(slaveArAddr), .slaveArLen(slaveArLen),
		.slaveArSize(slaveArSize), .slaveArBurst(slaveArBurst),
		.slaveArLock(slaveArLock), .slaveArCache(slaveArCache),
		.slaveArProt(slaveArProt)
	);

	rdataReturn rdReturn (
		.ACLK(ACLK), .sysReset(sysReset),
		.reqRecord(reqRecord), .reqEmpty(reqEmpty), .reqPop(reqPop),
		.beatData(beatData), .beatResp(beatResp),
		.beatEmpty(beatEmpty), .beatPop(beatPop),
		.rId(rId), .rData(rData), .rResp(rResp),
		.rLast(rLast), .rValid(rValid), .rReady(rReady)
	);

endmodule

/* verification/readProtConvTb.sv */
`timescale 1ns/100ps

module readProtConvTb import axi3ReadPkg::*; ();

	logic    ACLK;
	logic    sysReset;
	idT      arId;
	addrT    arAddr;
	axi4LenT arLen;
	sizeT    arSize;
	burstT   arBurst;
	lockT    arLock;
	cacheT   arCache;
	protT    arProt;
	logic    arValid;
	logic    arReady;
	idT      rId;
	dataT    rData;
	respT    rResp;
	logic    rLast;
	logic    rValid;
	logic    rReady;
	idT      slaveArId;
	addrT    slaveArAddr;
	axi3LenT slaveArLen;
	sizeT    slaveArSize;
	burstT   slaveArBurst;
	lockT    slaveArLock;
	cacheT   slaveArCache;
	protT    slaveArProt;
	logic    slaveArValid;
	logic    slaveArReady;
	dataT    slaveRData;
	respT    slaveRResp;
	logic    slaveRLast;
	logic    slaveRValid;
	logic    slaveRReady;

	localparam burstT burstIncr = 2'b01;

	logic [39:0] expArQ[$];     // {id, AXI3 len, addr} in issue order
	logic [13:0] expAttrQ[$];   // {size, burst, lock, cache, prot} per segment
	logic [38:0] expBeatQ[$];   // {id, last, resp, data} in upstream order
	logic [39:0] slvSegQ[$];    // Segments accepted by the slave model
	logic [31:0] rngState = 32'd71;
	logic        useGaps = 1'b0;   // Random ready and valid gaps
	logic        rTaken = 1'b0;    // Slave beat handshake at the coming edge
	int          errorCount = 0;
	int          errorsAtStart = 0;
	int          testCount = 0;
	int          segsChecked = 0;
	int          beatsChecked = 0;

	readProtConv dut (.*);

	initial
	begin
		ACLK = 1'b0;
		forever
			#4 ACLK = ~ACLK;   // 8 ns period
	end

	// ==================================================================
	// Random numbers and expected results
	// ==================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	function automatic logic randomBusy();   // About one cycle in four
		logic [31:0] r;
		r = nextRandom();
		return useGaps && (r[1:0] == 2'b00);
	endfunction

	// Expected segments and upstream beats of one request
	function automatic void buildExpected(input idT id, input addrT addr, input axi4LenT len,
		input sizeT size, input burstT burst, input lockT lock, input cacheT cache,
		input protT prot);
		int   beatsLeft;
		int   segBeats;
		addrT segAddr;
		respT resp;
		dataT d;
		beatsLeft = int'(len) + 1;
		segAddr = addr;
		while (beatsLeft > 0)
		begin
			segBeats = (beatsLeft > axi3MaxBeats) ? axi3MaxBeats : beatsLeft;
			expArQ.push_back({id, axi3LenT'(segBeats - 1), segAddr});
			expAttrQ.push_back({size, burst, lock, cache, prot});
			resp = segAddr[12] ? 2'b10 : 2'b00;   // SLVERR region
			for (int i = 0; i < segBeats; i++)
			begin
				d = segAddr ^ dataT'(i) ^ dataT'(id);
				expBeatQ.push_back({id, (beatsLeft == segBeats) && (i == segBeats - 1), resp, d});
			end
			beatsLeft -= segBeats;
			if (burst != burstFixed)
				segAddr = ((segAddr >> size) + addrT'(axi3MaxBeats)) << size;  // Whole beats on
		end
	endfunction

	// ==================================================================
	// Compare tasks
	// ==================================================================
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic checkAr(input addrT gotAddr, input axi3LenT gotLen, input idT gotId);
		logic [39:0] want;
		segsChecked++;
		if (expArQ.size() == 0)
		begin
			errorCount++;
			$display("ERROR %0t: unexpected AXI3 segment at %h", $time, gotAddr);
		end
		else
		begin
			want = expArQ.pop_front();
			if ({gotId, gotLen, gotAddr} !== want)
			begin
				errorCount++;
				$display("ERROR %0t: segment addr %h len %0d id %0d, expected %h %0d %0d",
					$time, gotAddr, gotLen, gotId, want[31:0], want[35:32], want[39:36]);
			end
		end
	endtask

	task automatic checkArAttr(input sizeT gotSize, input burstT gotBurst, input lockT gotLock,
		input cacheT gotCache, input protT gotProt);
		logic [13:0] want;
		if (expAttrQ.size() != 0)
		begin
			want = expAttrQ.pop_front();
			if ({gotSize, gotBurst, gotLock, gotCache, gotProt} !== want)
			begin
				errorCount++;
				$display("ERROR %0t: segment size/burst/lock/cache/prot %h, expected %h",
					$time, {gotSize, gotBurst, gotLock, gotCache, gotProt}, want);
			end
		end
	endtask

	task automatic checkBeat(input dataT gotData, input respT gotResp, input logic gotLast,
		input idT gotId);
		logic [38:0] want;
		beatsChecked++;
		if (expBeatQ.size() == 0)
		begin
			errorCount++;
			$display("ERROR %0t: unexpected upstream beat, data %h", $time, gotData);
		end
		else
		begin
			want = expBeatQ.pop_front();
			if ({gotId, gotLast, gotResp, gotData} !== want)
			begin
				errorCount++;
				$display("ERROR %0t: beat data %h resp %0d last %b id %0d, expected %h %0d %b %0d",
					$time, gotData, gotResp, gotLast, gotId,
					want[31:0], want[33:32], want[34], want[38:35]);
			end
		end
	endtask

	// Handshakes sampled at the falling edge, transfer at the next rising edge
	initial
	begin
		forever
		begin
			@(negedge ACLK);
			if (slaveArValid && slaveArReady)
			begin
				slvSegQ.push_back({slaveArId, slaveArLen, slaveArAddr});
				checkAr(slaveArAddr, slaveArLen, slaveArId);
				checkArAttr(slaveArSize, slaveArBurst, slaveArLock, slaveArCache, slaveArProt);
			end
			rTaken = slaveRValid && slaveRReady;
			if (rValid && rReady)
				checkBeat(rData, rResp, rLast, rId);
		end
	end

	// ==================================================================
	// AXI3 slave model and upstream ready
	// ==================================================================
	initial
	begin
		logic [39:0] seg;
		logic [3:0]  slvBeat;
		slvBeat = '0;
		forever
		begin
			@(posedge ACLK);
			#1;
			slaveArReady = !randomBusy();
			rReady = !randomBusy();   // Upstream back-pressure
			if (rTaken)
			begin
				if (slvBeat == slvSegQ[0][35:32])
				begin
					void'(slvSegQ.pop_front());   // Segment complete
					slvBeat = '0;
				end
				else
					slvBeat++;
			end
			if (!slaveRValid || rTaken)   // Valid holds until taken
			begin
				if ((slvSegQ.size() > 0) && !randomBusy())
				begin
					seg = slvSegQ[0];
					slaveRData = seg[31:0] ^ dataT'(slvBeat) ^ dataT'(seg[39:36]);
					slaveRResp = seg[12] ? 2'b10 : 2'b00;
					slaveRLast = (slvBeat == seg[35:32]);
					slaveRValid = 1'b1;
				end
				else
					slaveRValid = 1'b0;
			end
		end
	end

	// ==================================================================
	// Upstream master
	// ==================================================================
	task automatic sendRequest(input idT id, input addrT addr, input axi4LenT len,
		input sizeT size, input burstT burst);
		int    waitCycles;
		lockT  lock;
		cacheT cache;
		protT  prot;
		lock = lockT'(id);      // Attributes vary with the ID
		cache = ~cacheT'(id);
		prot = protT'(id);
		buildExpected(id, addr, len, size, burst, lock, cache, prot);
		arId = id;
		arAddr = addr;
		arLen = len;
		arSize = size;
		arBurst = burst;
		arLock = lock;
		arCache = cache;
		arProt = prot;
		arValid = 1'b1;
		waitCycles = 0;
		@(negedge ACLK);
		while (!arReady)
		begin
			waitCycles++;
			if (waitCycles > 1000)
				abortRun("Request was never accepted, arReady stayed low");
			@(negedge ACLK);
		end
		@(posedge ACLK);
		#1;
		arValid = 1'b0;
	endtask

	task automatic finishTest(input string name);
		int waitCycles;
		waitCycles = 0;
		while ((expArQ.size() != 0) || (expBeatQ.size() != 0))
		begin
			waitCycles++;
			if (waitCycles > 5000)
				abortRun({"Test ", name, " stalled before all segments and beats arrived"});
			@(negedge ACLK);
		end
		@(posedge ACLK);
		#1;
		testCount++;
		$display("Test %0d %s: %s", testCount, name,
			(errorCount == errorsAtStart) ? "passed" : "failed");
		errorsAtStart = errorCount;
	endtask

	initial
	begin
		logic [31:0] r;
		sysReset = 1'b0;
		arId = '0;
		arAddr = '0;
		arLen = '0;
		arSize = '0;
		arBurst = '0;
		arLock = '0;
		arCache = 4'h3;
		arProt = '0;
		arValid = 1'b0;
		rReady = 1'b1;
		slaveArReady = 1'b1;
		slaveRData = '0;
		slaveRResp = '0;
		slaveRLast = 1'b0;
		slaveRValid = 1'b0;
		repeat (2) @(posedge ACLK);
		#1;
		sysReset = 1'b1;

		sendRequest(4'h1, 32'h0000_0100, 8'd9, 3'd2, burstIncr);
		finishTest("incr length 9");
		sendRequest(4'h2, 32'h0000_0400, 8'd255, 3'd2, burstIncr);
		finishTest("incr length 255");
		sendRequest(4'h3, 32'h0000_0840, 8'd40, 3'd2, burstFixed);
		finishTest("fixed length 40");
		sendRequest(4'h4, 32'h0000_2005, 8'd20, 3'd3, burstIncr);
		finishTest("unaligned size 3");

		useGaps = 1'b1;
		sendRequest(4'h5, 32'h0000_0F80, 8'd63, 3'd2, burstIncr);   // Crosses into SLVERR
		for (int k = 0; k < 4; k++)
		begin
			r = nextRandom();
			sendRequest(idT'(k + 6), r[31:16] & 32'h0000_1FFC, axi4LenT'(r[5:0]), 3'd2, burstIncr);
		end
		finishTest("random gaps and errors");

		for (int k = 0; k < 5; k++)
			sendRequest(idT'(k + 10), 32'h0000_3000 + 32'(k * 'h200), axi4LenT'(k * 7 + 3),
				3'd2, burstIncr);
		finishTest("back to back ids");

		$display("Tests %0d, segments %0d, beats %0d, errors %0d",
			testCount, segsChecked, beatsChecked, errorCount);
		if (errorCount == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

/* readProtConv.f */
verilog/axi3ReadPkg.sv
verilog/syncFifo.sv
verilog/arSplitFsm.sv
verilog/arSegmentGen.sv
verilog/rdataReturn.sv
verilog/readProtConv.sv
verification/readProtConvTb.sv

/* run.sh */
#!/bin/sh
# Build and run the readProtConv testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal \
	--top-module readProtConvTb \
	-f readProtConv.f \
	-o readProtConvSim
./obj_dir/readProtConvSim | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
